//--- hdl/noc_settings.svh
/* NoC router build settings */

`ifndef NOC_SETTINGS_SVH
`define NOC_SETTINGS_SVH

// Flit and buffer sizing
`define FLIT_W 16
`define BUF_DEPTH 4

// N, W and L only on this corner
`define NUM_PORTS 3

// Destination address fields inside a flit
`define ADDR_Y_MSB 15
`define ADDR_Y_LSB 12
`define ADDR_X_MSB 11
`define ADDR_X_LSB 8

// Payload in the low byte
`define PAYLOAD_MSB 7
`define PAYLOAD_LSB 0

`endif

//--- hdl/noc_pkg.sv
/* NoC router types */

`include "noc_settings.svh"

package noc_pkg;

  // Port identifier, also the round-robin pointer state
  typedef enum logic [1:0] {
    PORT_N = 2'd0,
    PORT_W = 2'd1,
    PORT_L = 2'd2
  } port_e;

  // One single-flit packet
  typedef logic [`FLIT_W-1:0] flit_t;

  // Extra MSB tells full from empty
  typedef logic [$clog2(`BUF_DEPTH):0] buf_ptr_t;

endpackage

//--- hdl/input_buffer.sv
/* Input flit FIFO */

`timescale 1ns/1ps
`include "noc_settings.svh"

module input_buffer import noc_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_i,
  input  logic  wr_i,
  input  logic  pop_i,
  input  flit_t data_i,
  output flit_t head_o,
  output logic  empty_o,
  output logic  credit_o
);

  localparam int ADDR_W = $clog2(`BUF_DEPTH);

  flit_t    mem [`BUF_DEPTH];
  buf_ptr_t wr_ptr;
  buf_ptr_t rd_ptr;
  logic     full;
  logic     do_write;
  logic     do_pop;

  // Same index, wrap bits differ when full
  assign empty_o = (wr_ptr == rd_ptr);
  assign full    = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                   (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);

  assign do_write = wr_i && !full;
  assign do_pop   = pop_i && !empty_o;

  // Head read is asynchronous
  assign head_o = mem[rd_ptr[ADDR_W-1:0]];

  always_ff @(posedge clk_i) begin
    if (do_write) begin
      mem[wr_ptr[ADDR_W-1:0]] <= data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_write) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // One credit back upstream per popped flit
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      credit_o <= 1'b0;
    end else begin
      credit_o <= do_pop;
    end
  end

endmodule

//--- hdl/credit_counter.sv
/* Downstream credit counter */

`timescale 1ns/1ps
`include "noc_settings.svh"

module credit_counter (
  input  logic clk_i,
  input  logic rst_i,
  input  logic inc_i,
  input  logic dec_i,
  output logic avail_o
);

  localparam int CNT_W = $clog2(`BUF_DEPTH + 1);
  localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(`BUF_DEPTH);

  logic [CNT_W-1:0] count;

  // Free slots in the downstream buffer
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      count <= FULL_CNT;
    end else if (inc_i && !dec_i) begin
      if (count != FULL_CNT) begin
        count <= count + 1'b1;
      end
    end else if (dec_i && !inc_i) begin
      if (count != '0) begin
        count <= count - 1'b1;
      end
    end
  end

  assign avail_o = (count != '0);

endmodule

//--- hdl/route_arbiter.sv
/* YX route and round-robin arbiter */

`timescale 1ns/1ps
`include "noc_settings.svh"

module route_arbiter import noc_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic [15:0]           router_addr_i,
  input  flit_t                 head_i [`NUM_PORTS],
  input  logic [`NUM_PORTS-1:0] empty_i,
  input  logic [`NUM_PORTS-1:0] credit_avail_i,
  output logic [`NUM_PORTS-1:0] pop_o,
  output logic [`NUM_PORTS-1:0] grant_valid_o,
  output port_e                 grant_sel_o [`NUM_PORTS]
);

  port_e                 route [`NUM_PORTS];
  logic [`NUM_PORTS-1:0] req [`NUM_PORTS];
  port_e                 rr_ptr [`NUM_PORTS];

  // Next port in N, W, L order
  function automatic port_e next_port(input port_e p);
    case (p)
      PORT_N:  next_port = PORT_W;
      PORT_W:  next_port = PORT_L;
      default: next_port = PORT_N;
    endcase
  endfunction

  // Y first, then X; south and east fall to local
  function automatic port_e yx_route(input flit_t f, input logic [15:0] addr);
    logic [`ADDR_Y_MSB-`ADDR_Y_LSB:0] dst_y;
    logic [`ADDR_X_MSB-`ADDR_X_LSB:0] dst_x;
    logic [`ADDR_Y_MSB-`ADDR_Y_LSB:0] own_y;
    logic [`ADDR_X_MSB-`ADDR_X_LSB:0] own_x;
    dst_y = f[`ADDR_Y_MSB:`ADDR_Y_LSB];
    dst_x = f[`ADDR_X_MSB:`ADDR_X_LSB];
    own_y = addr[`ADDR_Y_MSB:`ADDR_Y_LSB];
    own_x = addr[`ADDR_X_MSB:`ADDR_X_LSB];
    if (dst_y < own_y) begin
      yx_route = PORT_N;
    end else if (dst_x < own_x) begin
      yx_route = PORT_W;
    end else begin
      yx_route = PORT_L;
    end
  endfunction

  // Request matrix, indexed output then input
  always_comb begin
    for (int i = 0; i < `NUM_PORTS; i++) begin
      route[i] = yx_route(head_i[i], router_addr_i);
    end
    for (int o = 0; o < `NUM_PORTS; o++) begin
      for (int i = 0; i < `NUM_PORTS; i++) begin
        req[o][i] = !empty_i[i] && (route[i] == port_e'(o));
      end
    end
  end

  // First requester after the pointer wins
  always_comb begin
    port_e cand;
    cand = PORT_N;
    for (int o = 0; o < `NUM_PORTS; o++) begin
      grant_valid_o[o] = 1'b0;
      grant_sel_o[o]   = PORT_N;
      if (credit_avail_i[o]) begin
        cand = rr_ptr[o];
        for (int k = 0; k < `NUM_PORTS; k++) begin
          cand = next_port(cand);
          if (!grant_valid_o[o] && req[o][cand]) begin
            grant_valid_o[o] = 1'b1;
            grant_sel_o[o]   = cand;
          end
        end
      end
    end
  end

  // An input requests one output, so one pop at most
  always_comb begin
    for (int i = 0; i < `NUM_PORTS; i++) begin
      pop_o[i] = 1'b0;
      for (int o = 0; o < `NUM_PORTS; o++) begin
        if (grant_valid_o[o] && (grant_sel_o[o] == port_e'(i))) begin
          pop_o[i] = 1'b1;
        end
      end
    end
  end

  // Start at L so N is served first
  always_ff @(posedge clk_i) begin
    for (int o = 0; o < `NUM_PORTS; o++) begin
      if (rst_i) begin
        rr_ptr[o] <= PORT_L;
      end else if (grant_valid_o[o]) begin
        rr_ptr[o] <= grant_sel_o[o];
      end
    end
  end

endmodule

//--- hdl/crossbar_switch.sv
/* Registered crossbar */

`timescale 1ns/1ps
`include "noc_settings.svh"

module crossbar_switch import noc_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  flit_t                 in_flit_i [`NUM_PORTS],
  input  logic [`NUM_PORTS-1:0] grant_valid_i,
  input  port_e                 grant_sel_i [`NUM_PORTS],
  output flit_t                 out_flit_o [`NUM_PORTS],
  output logic [`NUM_PORTS-1:0] out_valid_o
);

  flit_t sel_flit [`NUM_PORTS];

  // Per-output mux over input heads
  always_comb begin
    for (int o = 0; o < `NUM_PORTS; o++) begin
      case (grant_sel_i[o])
        PORT_W:  sel_flit[o] = in_flit_i[PORT_W];
        PORT_L:  sel_flit[o] = in_flit_i[PORT_L];
        default: sel_flit[o] = in_flit_i[PORT_N];
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    for (int o = 0; o < `NUM_PORTS; o++) begin
      if (grant_valid_i[o]) begin
        out_flit_o[o] <= sel_flit[o];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      out_valid_o <= '0;
    end else begin
      out_valid_o <= grant_valid_i;
    end
  end

endmodule

//--- hdl/se_corner_router.sv
/* South-east corner router */

`timescale 1ns/1ps
`include "noc_settings.svh"

module se_corner_router import noc_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic [15:0] yx_addr_router_i,
  input  flit_t       n_data_i,
  input  logic        n_valid_i,
  input  logic        n_credit_i,
  input  flit_t       w_data_i,
  input  logic        w_valid_i,
  input  logic        w_credit_i,
  input  flit_t       l_data_i,
  input  logic        l_valid_i,
  input  logic        l_credit_i,
  output flit_t       n_data_o,
  output logic        n_valid_o,
  output logic        n_credit_o,
  output flit_t       w_data_o,
  output logic        w_valid_o,
  output logic        w_credit_o,
  output flit_t       l_data_o,
  output logic        l_valid_o,
  output logic        l_credit_o
);

  flit_t                 in_data [`NUM_PORTS];
  logic [`NUM_PORTS-1:0] in_valid;
  logic [`NUM_PORTS-1:0] credit_in;
  logic [`NUM_PORTS-1:0] credit_out;
  flit_t                 head [`NUM_PORTS];
  logic [`NUM_PORTS-1:0] empty;
  logic [`NUM_PORTS-1:0] pop;
  logic [`NUM_PORTS-1:0] credit_avail;
  logic [`NUM_PORTS-1:0] grant_valid;
  port_e                 grant_sel [`NUM_PORTS];
  flit_t                 out_data [`NUM_PORTS];
  logic [`NUM_PORTS-1:0] out_valid;

  // Named ports into per-port arrays
  assign in_data[PORT_N]   = n_data_i;
  assign in_data[PORT_W]   = w_data_i;
  assign in_data[PORT_L]   = l_data_i;
  assign in_valid          = {l_valid_i, w_valid_i, n_valid_i};
  assign credit_in         = {l_credit_i, w_credit_i, n_credit_i};

  assign n_data_o   = out_data[PORT_N];
  assign w_data_o   = out_data[PORT_W];
  assign l_data_o   = out_data[PORT_L];
  assign n_valid_o  = out_valid[PORT_N];
  assign w_valid_o  = out_valid[PORT_W];
  assign l_valid_o  = out_valid[PORT_L];
  assign n_credit_o = credit_out[PORT_N];
  assign w_credit_o = credit_out[PORT_W];
  assign l_credit_o = credit_out[PORT_L];

  for (genvar g = 0; g < `NUM_PORTS; g++) begin : g_ib
    input_buffer ib_i (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .wr_i     (in_valid[g]),
      .pop_i    (pop[g]),
      .data_i   (in_data[g]),
      .head_o   (head[g]),
      .empty_o  (empty[g]),
      .credit_o (credit_out[g])
    );
  end

  // A grant spends one downstream credit
  for (genvar g = 0; g < `NUM_PORTS; g++) begin : g_cc
    credit_counter cc_i (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .inc_i   (credit_in[g]),
      .dec_i   (grant_valid[g]),
      .avail_o (credit_avail[g])
    );
  end

  route_arbiter arb_i (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .router_addr_i  (yx_addr_router_i),
    .head_i         (head),
    .empty_i        (empty),
    .credit_avail_i (credit_avail),
    .pop_o          (pop),
    .grant_valid_o  (grant_valid),
    .grant_sel_o    (grant_sel)
  );

  crossbar_switch cs_i (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .in_flit_i     (head),
    .grant_valid_i (grant_valid),
    .grant_sel_i   (grant_sel),
    .out_flit_o    (out_data),
    .out_valid_o   (out_valid)
  );

endmodule

//--- test/se_corner_router_tb.sv
/* Corner router testbench */

`timescale 1ns/1ps
`include "noc_settings.svh"

module se_corner_router_tb import noc_pkg::*; ();

  localparam int MAX_PKT = 64;

  logic       clk = 1'b0;
  logic       rst;
  flit_t      data_in [3];
  logic [2:0] valid_in;
  logic [2:0] credit_in;
  flit_t      data_out [3];
  logic [2:0] valid_out;
  logic [2:0] credit_out;

  flit_t send_flit [3][MAX_PKT];
  int    send_phase [3][MAX_PKT];
  int    send_cnt [3];
  int    send_idx [3];
  int    gap [3];
  int    sent [3];
  int    returned [3];
  flit_t exp_flit [3][MAX_PKT];
  int    exp_phase [3][MAX_PKT];
  bit    exp_done [3][MAX_PKT];
  int    exp_cnt [3];
  int    phase_total [2];
  int    delivered [2];
  int    owed [3];
  int    valid_seen [3];
  int    credit_given [3];
  int    last_seq [4][3];
  int    last_l_tag;
  int    num_lines;
  int    cur_phase;
  bit    withhold;
  bit    any_sent;
  bit    load_ok;
  int    err_reset, err_route, err_order, err_bp, err_fair, err_credit;
  int    tests_passed, tests_failed;
  logic [31:0] lfsr_state;

  se_corner_router se_corner_router_i (
    .clk_i            (clk),
    .rst_i            (rst),
    .yx_addr_router_i (16'h3300),
    .n_data_i         (data_in[0]),
    .n_valid_i        (valid_in[0]),
    .n_credit_i       (credit_in[0]),
    .w_data_i         (data_in[1]),
    .w_valid_i        (valid_in[1]),
    .w_credit_i       (credit_in[1]),
    .l_data_i         (data_in[2]),
    .l_valid_i        (valid_in[2]),
    .l_credit_i       (credit_in[2]),
    .n_data_o         (data_out[0]),
    .n_valid_o        (valid_out[0]),
    .n_credit_o       (credit_out[0]),
    .w_data_o         (data_out[1]),
    .w_valid_o        (valid_out[1]),
    .w_credit_o       (credit_out[1]),
    .l_data_o         (data_out[2]),
    .l_valid_o        (valid_out[2]),
    .l_credit_o       (credit_out[2])
  );

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  initial begin
    forever #2 clk = ~clk;
  end

  task automatic load_golden(output bit ok);
    int    fd;
    int    ph;
    int    ip;
    int    op;
    flit_t fl;
    string line;
    ph = 0;
    ok = 1'b0;
    fd = $fopen("test/router_golden.txt", "r");
    if (fd != 0) begin
      ok = 1'b1;
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() < 2 || line[0] == "#") continue;
        if ($sscanf(line, "phase %d", ph) == 1) continue;
        if ($sscanf(line, "%d %h %d", ip, fl, op) == 3) begin
          send_flit[ip][send_cnt[ip]] = fl;
          send_phase[ip][send_cnt[ip]] = ph;
          send_cnt[ip]++;
          exp_flit[op][exp_cnt[op]] = fl;
          exp_phase[op][exp_cnt[op]] = ph;
          exp_cnt[op]++;
          phase_total[ph]++;
          num_lines++;
        end
      end
      $fclose(fd);
    end
  endtask

  // Upstream drivers and downstream credit return
  always @(posedge clk) begin
    for (int p = 0; p < 3; p++) begin
      valid_in[p]  <= 1'b0;
      credit_in[p] <= 1'b0;
      if (!rst) begin
        if (gap[p] > 0) begin
          gap[p]--;
        end else if (send_idx[p] < send_cnt[p] && send_phase[p][send_idx[p]] <= cur_phase &&
                     sent[p] - returned[p] < `BUF_DEPTH) begin
          data_in[p]  <= send_flit[p][send_idx[p]];
          valid_in[p] <= 1'b1;
          send_idx[p]++;
          sent[p]++;
          any_sent = 1'b1;
          // Back-to-back in the fairness phase
          if (cur_phase == 0) begin
            gap[p] = int'({lfsr_bit(), lfsr_bit()});
          end
        end
        if (owed[p] > 0 && !withhold && lfsr_bit()) begin
          credit_in[p] <= 1'b1;
          owed[p]--;
          credit_given[p]++;
        end
      end
    end
  end

  task automatic check_flit(input int o, input flit_t f);
    int tag;
    int seq;
    int hit;
    int other;
    int other_k;
    tag = int'(f[7:6]);
    seq = int'(f[5:0]);
    hit = -1;
    other = -1;
    other_k = -1;
    for (int k = 0; k < exp_cnt[o]; k++) begin
      if (exp_flit[o][k] == f && !exp_done[o][k]) hit = k;
    end
    for (int q = 0; q < 3; q++) begin
      for (int k = 0; k < exp_cnt[q]; k++) begin
        if (q != o && exp_flit[q][k] == f && !exp_done[q][k]) begin
          other = q;
          other_k = k;
        end
      end
    end
    assert (hit >= 0 || other < 0) else begin
      $display("[ERROR] %0t: flit %h left on port %0d, expected port %0d", $time, f, o, other);
      err_route++;
      exp_done[other][other_k] = 1'b1;
      delivered[exp_phase[other][other_k]]++;
    end
    assert (hit >= 0 || other >= 0) else begin
      $display("[ERROR] %0t: unexpected or repeated flit %h on port %0d", $time, f, o);
      err_order++;
    end
    if (hit >= 0) begin
      exp_done[o][hit] = 1'b1;
      delivered[exp_phase[o][hit]]++;
      assert (seq > last_seq[tag][o]) else begin
        $display("[ERROR] %0t: flit %h on port %0d out of order", $time, f, o);
        err_order++;
      end
      last_seq[tag][o] = seq;
      if (exp_phase[o][hit] == 1 && o == 2) begin
        assert (tag != last_l_tag) else begin
          $display("[ERROR] %0t: source tag %0d served twice in a row on L", $time, tag);
          err_fair++;
        end
        last_l_tag = tag;
      end
    end
  endtask

  // Outputs are sampled mid-cycle
  always @(negedge clk) begin
    if (rst || !any_sent) begin
      assert (valid_out == '0 && credit_out == '0) else begin
        $display("[ERROR] %0t: valid or credit output high before first input", $time);
        err_reset++;
      end
    end
    if (!rst) begin
      for (int p = 0; p < 3; p++) begin
        if (credit_out[p]) returned[p]++;
        if (valid_out[p]) begin
          check_flit(p, data_out[p]);
          valid_seen[p]++;
          owed[p]++;
        end
        assert (valid_seen[p] - credit_given[p] <= `BUF_DEPTH) else begin
          $display("[ERROR] %0t: port %0d sent more flits than credits", $time, p);
          err_bp++;
        end
      end
    end
  end

  task automatic report(input string name, input int n);
    $display("test %-16s %s (%0d errors)", name, (n == 0) ? "pass" : "fail", n);
    if (n == 0) tests_passed++;
    else tests_failed++;
  endtask

  task automatic drain();
    wait (owed[0] == 0 && owed[1] == 0 && owed[2] == 0);
    repeat (10) @(posedge clk);
  endtask

  task automatic run_all();
    int total;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    cur_phase = 0;
    wait (delivered[0] == phase_total[0]);
    drain();
    report("reset", err_reset);
    report("routing", err_route);

    // With credits held back L must stall at a full downstream buffer
    withhold = 1'b1;
    cur_phase = 1;
    repeat (40) @(posedge clk);
    assert (valid_seen[2] - credit_given[2] == `BUF_DEPTH) else begin
      $display("[ERROR] %0t: L output did not stall with credits withheld", $time);
      err_bp++;
    end
    withhold = 1'b0;
    wait (delivered[1] == phase_total[1]);
    drain();
    report("back-pressure", err_bp);
    report("fairness", err_fair);

    for (int o = 0; o < 3; o++) begin
      for (int k = 0; k < exp_cnt[o]; k++) begin
        assert (exp_done[o][k]) else begin
          $display("[ERROR] %0t: flit %h never left port %0d", $time, exp_flit[o][k], o);
          err_order++;
        end
      end
    end
    report("delivery/order", err_order);
    for (int p = 0; p < 3; p++) begin
      assert (returned[p] == sent[p]) else begin
        $display("[ERROR] %0t: port %0d returned %0d credits for %0d flits",
                 $time, p, returned[p], sent[p]);
        err_credit++;
      end
    end
    report("credit return", err_credit);

    total = err_reset + err_route + err_order + err_bp + err_fair + err_credit;
    $display("%0d tests passed, %0d failed, %0d errors", tests_passed, tests_failed, total);
    if (total == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  endtask

  initial begin
    rst <= 1'b1;
    valid_in <= '0;
    credit_in <= '0;
    for (int p = 0; p < 3; p++) begin
      data_in[p] <= '0;
      for (int t = 0; t < 4; t++) last_seq[t][p] = -1;
    end
    last_l_tag = 3;
    cur_phase = -1;
    lfsr_state = 32'h743c85b8;
    load_golden(load_ok);
    if (!load_ok) begin
      $display("could not open the golden stimulus file");
      $display("ERRORS FOUND");
      $finish;
    end else begin
      run_all();
    end
  end

  // Watchdog scaled to the golden file length
  initial begin
    #1;
    repeat (200 * num_lines) @(posedge clk);
    $display("watchdog expired before all flits were delivered");
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

//--- test/router_golden.txt
# input port (0=N 1=W 2=L), flit in hex {y, x, tag, seq}, expected output port
# "phase 0" is mixed traffic, "phase 1" fills N and W toward L with credits withheld
phase 0
0 1300 0
0 3001 1
0 3302 2
0 0503 0
0 4104 1
0 5505 2
0 2206 0
0 3207 1
1 3340 2
1 1141 0
1 3142 1
1 6443 2
1 0044 0
1 7045 1
1 3946 2
1 2747 0
2 0380 0
2 3281 1
2 3382 2
2 2083 0
2 4084 1
2 9985 2
2 1886 0
2 3387 2
phase 1
0 3308 2
1 4548 2
0 3309 2
1 4549 2
0 330a 2
1 454a 2
0 330b 2
1 454b 2
0 330c 2
1 454c 2
0 330d 2
1 454d 2

//--- files.f
+incdir+hdl
hdl/noc_pkg.sv
hdl/input_buffer.sv
hdl/credit_counter.sv
hdl/route_arbiter.sv
hdl/crossbar_switch.sv
hdl/se_corner_router.sv
test/se_corner_router_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the router testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module se_corner_router_tb -f files.f &&
./obj_dir/Vse_corner_router_tb | grep -q "NO ERRORS" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
